// ==== list.f ====
rtl/conv_pkg.sv
rtl/step_buffer.sv
rtl/mac_multiplier.sv
rtl/mac_accumulator.sv
rtl/conv_unit.sv
rtl/conv_csr.sv
rtl/conv_output_stage.sv
rtl/conv_top.sv
tb/conv_tb.sv

// ==== rtl/conv_csr.sv ====
// Wishbone control registers
module conv_csr
    import conv_pkg::*;
(
    input  logic               aclk,
    input  logic               rst,
    input  wb_req_t            wb_req,
    output wb_rsp_t            wb_rsp,
    input  logic               out_fire,   // Any output lane taken this cycle
    output logic               relu_en,
    output logic [SHIFT_W-1:0] out_shift
);

    logic        access;    // New request, not the ack cycle
    logic        ctrl_wr;
    logic        shift_wr;
    logic        ack_q;
    logic [31:0] count_q;   // Output transfers seen
    logic [31:0] rd_data;
    logic [31:0] rd_q;

    assign access   = wb_req.cyc & wb_req.stb & ~ack_q;
    assign ctrl_wr  = access & wb_req.we & (wb_req.adr == CSR_CTRL);
    assign shift_wr = access & wb_req.we & (wb_req.adr == CSR_SHIFT);

    always_comb begin
        case (wb_req.adr)
            CSR_CTRL:  rd_data = {31'b0, relu_en};
            CSR_SHIFT: rd_data = {{(32 - SHIFT_W){1'b0}}, out_shift};
            CSR_COUNT: rd_data = count_q;
            default:   rd_data = 32'b0;  // Unmapped word reads zero
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            ack_q     <= 1'b0;
            relu_en   <= 1'b0;
            out_shift <= '0;
            count_q   <= 32'b0;
        end else begin
            ack_q <= access;  // One cycle pulse per access
            if (ctrl_wr) begin
                relu_en <= wb_req.dat[0];
            end
            if (shift_wr) begin
                out_shift <= wb_req.dat[SHIFT_W-1:0];
            end
            if (ctrl_wr) begin
                count_q <= 32'b0;  // CTRL write restarts the count
            end else if (out_fire) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    // Read word lands with the ack
    always_ff @(posedge aclk) begin
        if (access) begin
            rd_q <= rd_data;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_q};

endmodule

// ==== rtl/conv_output_stage.sv ====
// Output ReLU, shift and saturation
module conv_output_stage
    import conv_pkg::*;
(
    input  logic               aclk,
    input  logic               aclken,
    input  logic               rst,
    input  logic               relu_en,
    input  logic [SHIFT_W-1:0] out_shift,
    input  lane_t     [KW-1:0] s_lanes,
    output out_lane_t [KW-1:0] m_lanes
);

    for (genvar k = 0; k < KW; k++) begin : g_lane
        logic signed [ACC_W-1:0] rect;
        logic signed [ACC_W-1:0] shifted;
        logic signed [ACC_W-1:0] clipped;
        logic                    relu_on;
        out_lane_t               lane_q;

        // ReLU needs both the register bit and the beat's request
        assign relu_on = relu_en & s_lanes[k].user[USER_IS_RELU];
        assign rect    = (relu_on && s_lanes[k].sum[ACC_W-1]) ? '0 : s_lanes[k].sum;
        assign shifted = rect >>> out_shift;  // Arithmetic, keeps sign

        assign clipped = (shifted > OUT_MAX) ? OUT_MAX :
                         (shifted < OUT_MIN) ? OUT_MIN : shifted;

        always_ff @(posedge aclk) begin
            if (rst) begin
                lane_q.valid <= 1'b0;
            end else if (aclken) begin
                lane_q.valid <= s_lanes[k].valid & s_lanes[k].last;  // Block sums only
                lane_q.value <= OUT_W'(clipped);
            end
        end

        assign m_lanes[k] = lane_q;
    end

endmodule

// ==== rtl/conv_pkg.sv ====
// Row convolution definitions
package conv_pkg;

    localparam int KW        = 3;   // Kernel taps, one datapath per tap
    localparam int DATA_W    = 8;   // Signed pixel and weight
    localparam int ACC_W     = 24;  // Signed product and block sum
    localparam int OUT_W     = 16;  // Signed result after shift
    localparam int SHIFT_W   = 5;   // Output right shift amount
    localparam int MUL_DELAY = 3;
    localparam int ACC_DELAY = 3;   // Needs at least 2 for the hand-off skew
    localparam int USER_W    = 2;

    // User field bits
    localparam int USER_IS_1X1  = 0;
    localparam int USER_IS_RELU = 1;

    // Wishbone word addresses
    localparam logic [1:0] CSR_CTRL  = 2'd0;  // Bit 0 enables ReLU
    localparam logic [1:0] CSR_SHIFT = 2'd1;
    localparam logic [1:0] CSR_COUNT = 2'd2;  // Read only

    // Saturation bounds held at sum width
    localparam logic signed [ACC_W-1:0] OUT_MAX = ACC_W'((1 << (OUT_W - 1)) - 1);
    localparam logic signed [ACC_W-1:0] OUT_MIN = ACC_W'(-(1 << (OUT_W - 1)));

    typedef struct packed {
        logic                     valid;
        logic signed [DATA_W-1:0] pixel;
        logic                     last;   // Closes a block
        logic [USER_W-1:0]        user;
    } pix_beat_t;

    typedef struct packed {
        logic                     valid;
        logic signed [DATA_W-1:0] weight;
    } wgt_beat_t;

    typedef struct packed {
        logic                    valid;
        logic signed [ACC_W-1:0] sum;
        logic                    last;
        logic [USER_W-1:0]       user;
    } lane_t;

    typedef struct packed {
        logic                    valid;
        logic signed [OUT_W-1:0] value;
    } out_lane_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;  // Word address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// ==== rtl/conv_top.sv ====
// Row convolution top
module conv_top
    import conv_pkg::*;
(
    input  logic               aclk,
    input  logic               rst,
    input  pix_beat_t          s_beat,
    input  wgt_beat_t [KW-1:0] s_weights,
    output logic               s_ready,
    output out_lane_t [KW-1:0] m_lanes,
    input  logic               m_ready,    // Stalls the whole pipeline when low
    input  wb_req_t            wb_req,
    output wb_rsp_t            wb_rsp
);

    lane_t [KW-1:0]     unit_lanes;
    logic               relu_en;
    logic [SHIFT_W-1:0] out_shift;
    logic [KW-1:0]      lane_valid;
    logic               out_fire;

    for (genvar k = 0; k < KW; k++) begin : g_valid
        assign lane_valid[k] = m_lanes[k].valid;
    end

    assign out_fire = m_ready & (|lane_valid);  // One count per transfer cycle

    conv_unit u_unit (
        .aclk      (aclk),
        .aclken    (m_ready),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_weights (s_weights),
        .s_ready   (s_ready),
        .m_lanes   (unit_lanes)
    );

    conv_output_stage u_out (
        .aclk      (aclk),
        .aclken    (m_ready),
        .rst       (rst),
        .relu_en   (relu_en),
        .out_shift (out_shift),
        .s_lanes   (unit_lanes),
        .m_lanes   (m_lanes)
    );

    conv_csr u_csr (
        .aclk      (aclk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .out_fire  (out_fire),
        .relu_en   (relu_en),
        .out_shift (out_shift)
    );

endmodule

// ==== rtl/conv_unit.sv ====
// Row convolution unit
module conv_unit
    import conv_pkg::*;
(
    input  logic               aclk,
    input  logic               aclken,     // Global stall
    input  logic               rst,
    input  pix_beat_t          s_beat,
    input  wgt_beat_t [KW-1:0] s_weights,
    output logic               s_ready,
    output lane_t     [KW-1:0] m_lanes
);

    logic [KW-1:1]      sel;         // Lane k takes the upstream block sum
    logic [KW-1:1]      sel_in;
    logic [KW-1:1]      sel_upd;
    logic               sel_none;
    logic               clken_mul;
    logic [KW-1:0]      clken_acc;
    logic               mode_1x1_q;  // Mode of the last beat taken

    pix_beat_t [KW-1:0] buf_pix;
    wgt_beat_t [KW-1:0] buf_wgt;
    lane_t     [KW-1:0] mul_out;
    lane_t     [KW-1:0] acc_in;
    lane_t     [KW-1:0] acc_out;

    assign sel_none     = ~|sel;
    assign clken_mul    = aclken & sel_none;  // Multipliers freeze on any hand-off
    assign clken_acc[0] = clken_mul;
    assign s_ready      = clken_mul;

    always_ff @(posedge aclk) begin
        if (rst) begin
            mode_1x1_q <= 1'b0;
        end else if (s_beat.valid && s_ready) begin
            mode_1x1_q <= s_beat.user[USER_IS_1X1];
        end
    end

    // Same pixel goes to every lane, skewed per lane
    step_buffer #(.beat_t(pix_beat_t), .STEPS(KW)) u_pix_buf (
        .aclk   (aclk),
        .aclken (clken_mul),
        .rst    (rst),
        .is_1x1 (mode_1x1_q),
        .s_beat ({KW{s_beat}}),
        .m_beat (buf_pix)
    );

    step_buffer #(.beat_t(wgt_beat_t), .STEPS(KW)) u_wgt_buf (
        .aclk   (aclk),
        .aclken (clken_mul),
        .rst    (rst),
        .is_1x1 (mode_1x1_q),
        .s_beat (s_weights),
        .m_beat (buf_wgt)
    );

    for (genvar k = 0; k < KW; k++) begin : g_mac
        mac_multiplier u_mul (
            .aclk   (aclk),
            .aclken (clken_mul),
            .rst    (rst),
            .s_pix  (buf_pix[k]),
            .s_wgt  (buf_wgt[k]),
            .m_prod (mul_out[k])
        );

        mac_accumulator u_acc (
            .aclk   (aclk),
            .aclken (clken_acc[k]),
            .rst    (rst),
            .s_term (acc_in[k]),
            .m_sum  (acc_out[k])
        );

        // A result counts once, in the cycle its accumulator moves on
        assign m_lanes[k] = '{valid: acc_out[k].valid & clken_acc[k],
                              sum:   acc_out[k].sum,
                              last:  acc_out[k].last,
                              user:  acc_out[k].user};
    end

    assign acc_in[0] = mul_out[0];  // Lane 0 has nothing upstream

    for (genvar k = 1; k < KW; k++) begin : g_snake
        lane_t snake_term;

        // Only lane k runs while its own hand-off is pending
        assign clken_acc[k] = aclken & (sel_none | sel[k]);

        // Upstream final sum with last held back, opening the next block
        assign snake_term = '{valid: acc_out[k-1].valid & acc_out[k-1].last,
                              sum:   acc_out[k-1].sum,
                              last:  1'b0,
                              user:  acc_out[k-1].user};

        assign acc_in[k]  = sel[k] ? snake_term : mul_out[k];
        assign sel_in[k]  = mul_out[k].valid & mul_out[k].last &
                            ~mul_out[k].user[USER_IS_1X1];  // Never set in 1x1
        assign sel_upd[k] = acc_in[k].valid & clken_acc[k];
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            sel <= '0;
        end else begin
            for (int k = 1; k < KW; k++) begin
                if (sel_upd[k]) begin
                    sel[k] <= sel_in[k];  // Clears once the upstream sum is taken
                end
            end
        end
    end

endmodule

// ==== rtl/mac_accumulator.sv ====
// Pipelined block accumulator
module mac_accumulator
    import conv_pkg::*;
(
    input  logic  aclk,
    input  logic  aclken,
    input  logic  rst,
    input  lane_t s_term,
    output lane_t m_sum
);

    logic signed [ACC_W-1:0] run_sum;   // Sum of the open block
    logic signed [ACC_W-1:0] next_sum;
    logic                    fresh;     // Next valid term opens a block
    lane_t                   stage_in;
    lane_t [ACC_DELAY-1:0]   pipe;      // Several blocks may be in flight

    assign next_sum = fresh ? s_term.sum : run_sum + s_term.sum;

    always_comb begin
        stage_in.valid = s_term.valid;
        stage_in.sum   = next_sum;     // Partial sums leave too, last marks the final
        stage_in.last  = s_term.last;
        stage_in.user  = s_term.user;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            fresh <= 1'b1;
            for (int i = 0; i < ACC_DELAY; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else if (aclken) begin
            if (s_term.valid) begin
                run_sum <= next_sum;
                fresh   <= s_term.last;  // Restart on the beat after last
            end
            pipe[0] <= stage_in;
            for (int i = 1; i < ACC_DELAY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign m_sum = pipe[ACC_DELAY-1];

endmodule

// ==== rtl/mac_multiplier.sv ====
// Pipelined signed multiplier
module mac_multiplier
    import conv_pkg::*;
(
    input  logic      aclk,
    input  logic      aclken,
    input  logic      rst,
    input  pix_beat_t s_pix,
    input  wgt_beat_t s_wgt,
    output lane_t     m_prod
);

    logic signed [2*DATA_W-1:0] product;  // Full width, no overflow
    lane_t                      stage_in;
    lane_t [MUL_DELAY-1:0]      pipe;

    assign product = $signed(s_pix.pixel) * $signed(s_wgt.weight);

    always_comb begin
        stage_in.valid = s_pix.valid & s_wgt.valid;
        stage_in.sum   = ACC_W'(product);  // Sign extends
        stage_in.last  = s_pix.last;       // Side band rides with the product
        stage_in.user  = s_pix.user;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < MUL_DELAY; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else if (aclken) begin
            pipe[0] <= stage_in;
            for (int i = 1; i < MUL_DELAY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign m_prod = pipe[MUL_DELAY-1];

endmodule

// ==== rtl/step_buffer.sv ====
// Staircase delay buffer
module step_buffer
    import conv_pkg::*;
#(
    parameter type beat_t = pix_beat_t,
    parameter int  STEPS  = KW
)(
    input  logic              aclk,
    input  logic              aclken,
    input  logic              rst,
    input  logic              is_1x1,   // All lanes take the short path
    input  beat_t [STEPS-1:0] s_beat,
    output beat_t [STEPS-1:0] m_beat
);

    // Lane 1 trails lane 0 by ACC_DELAY-1 cycles
    // Each later lane trails by ACC_DELAY-2 more, as its upstream
    // accumulator also steps during its own hand-off cycle
    for (genvar k = 0; k < STEPS; k++) begin : g_lane
        localparam int DEPTH = (k == 0) ? 1 :
                               (ACC_DELAY - 1) + (k - 1) * (ACC_DELAY - 2) + 1;

        beat_t [DEPTH-1:0] taps;  // taps[0] is the newest beat

        always_ff @(posedge aclk) begin
            if (rst) begin
                taps <= '0;  // Clears the valid bits
            end else if (aclken) begin
                taps[0] <= s_beat[k];
                for (int i = 1; i < DEPTH; i++) begin
                    taps[i] <= taps[i-1];
                end
            end
        end

        // Bypass keeps every lane at one register in 1x1 mode
        assign m_beat[k] = is_1x1 ? taps[0] : taps[DEPTH-1];
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f list.f --top-module conv_tb -o conv_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/conv_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || grep -q "Regression passed" sim.log || exit 1
exit 0

// ==== tb/conv_tb.sv ====
// Row convolution testbench
module conv_tb
    import conv_pkg::*;
;
    localparam int NBLK      = 8;                 // Blocks per phase
    localparam int NPHASE    = 4;
    localparam int MAX_BEATS = NPHASE * NBLK * 6;
    localparam int TIMEOUT   = MAX_BEATS * 20 * 8 + 40000;

    logic               aclk;
    logic               rst;
    pix_beat_t          s_beat;
    wgt_beat_t [KW-1:0] s_weights;
    logic               s_ready;
    out_lane_t [KW-1:0] m_lanes;
    logic               m_ready = 1'b1;
    wb_req_t            wb_req;
    wb_rsp_t            wb_rsp;

    logic [31:0]        stim_state;               // Stimulus LCG
    logic [31:0]        rdy_state;                // m_ready gap LCG
    logic signed [OUT_W-1:0] exp_mem [KW][NBLK];  // Expected results per lane
    int                 rd_ptr [KW];
    int                 exp_cnt;
    logic [KW-1:0]      watch;                    // Lanes whose results are checked
    int                 seen_cnt;                 // Output transfers observed
    logic               any_valid;

    conv_top u_dut (
        .aclk      (aclk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_weights (s_weights),
        .s_ready   (s_ready),
        .m_lanes   (m_lanes),
        .m_ready   (m_ready),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    always #4 aclk = ~aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic fail_plain(input string msg);
        $display("Error: %s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ReLU, shift and clip as the output stage rules define them
    function automatic logic [OUT_W-1:0] post(input longint v, input bit relu, input int sh);
        longint r;
        r = (relu && v < 0) ? 0 : v;
        r = r >>> sh;
        if (r > 32767) r = 32767;
        if (r < -32768) r = -32768;
        return OUT_W'(r);
    endfunction

    // Drop m_ready about one cycle in four
    always @(posedge aclk) begin
        if (rst) begin
            m_ready <= 1'b1;
        end else begin
            rdy_state = lcg_next(rdy_state);
            m_ready   <= (rdy_state[17:16] != 2'd0);
        end
    end

    always_comb begin
        any_valid = 1'b0;
        for (int k = 0; k < KW; k++) any_valid |= m_lanes[k].valid;
    end

    always @(posedge aclk) begin
        if (rst) seen_cnt <= 0;
        else if (m_ready && any_valid) seen_cnt <= seen_cnt + 1;
    end

    for (genvar k = 0; k < KW; k++) begin : g_chk
        always @(posedge aclk) begin
            if (rst) rd_ptr[k] <= 0;
            else if (m_ready && m_lanes[k].valid && watch[k]) rd_ptr[k] <= rd_ptr[k] + 1;
        end

        assert property (@(posedge aclk) disable iff (rst)
            (m_ready && m_lanes[k].valid && watch[k]) |-> (rd_ptr[k] < exp_cnt))
            else fail_plain("an output lane gave more results than blocks were sent");

        assert property (@(posedge aclk) disable iff (rst)
            (m_ready && m_lanes[k].valid && watch[k] && rd_ptr[k] < exp_cnt)
            |-> (m_lanes[k].value == exp_mem[k][rd_ptr[k]]))
            else fail_value("m_lanes.value", 32'($sampled(exp_mem[k][rd_ptr[k]])),
                            32'($sampled(m_lanes[k].value)));
    end

    assert property (@(posedge aclk) disable iff (rst) !m_ready |=> $stable(m_lanes))
        else fail_plain("m_lanes changed while m_ready was low");
    assert property (@(posedge aclk) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
        else fail_plain("Wishbone ack lasted more than one cycle");
    assert property (@(posedge aclk) disable iff (rst) wb_rsp.ack |-> wb_req.cyc)
        else fail_plain("Wishbone ack came without a cycle");

    task automatic do_reset();
        rst <= 1'b1;
        repeat (3) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd);
        logic got;
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge aclk);
            got = wb_rsp.ack;
            rd  = wb_rsp.dat;
            @(posedge aclk);
        end while (!got);
        wb_req <= '0;
        @(posedge aclk);
    endtask

    task automatic wb_check(input logic [1:0] adr, input logic [31:0] exp, input string name);
        logic [31:0] rd;
        wb_access(1'b0, adr, 32'b0, rd);
        assert (rd == exp) else fail_value(name, exp, rd);
    endtask

    // Hold the beat until the DUT takes it
    task automatic send_beat(input logic signed [DATA_W-1:0] pix, input logic last,
                             input logic [USER_W-1:0] user,
                             input logic signed [DATA_W-1:0] w [KW]);
        logic taken;
        s_beat <= '{valid: 1'b1, pixel: pix, last: last, user: user};
        for (int k = 0; k < KW; k++) s_weights[k] <= '{valid: 1'b1, weight: w[k]};
        do begin
            @(negedge aclk);
            taken = s_ready;
            @(posedge aclk);
        end while (!taken);
    endtask

    task automatic run_phase(input bit one, input bit relu, input int sh, input bit extreme);
        longint                   p [KW][NBLK];
        logic signed [DATA_W-1:0] w [KW];
        logic signed [DATA_W-1:0] pix;
        logic [USER_W-1:0]        user;
        logic [31:0]              rd;
        longint                   acc;
        int                       len;
        int                       idx;
        do_reset();
        wb_access(1'b1, CSR_CTRL, {31'b0, relu}, rd);
        wb_access(1'b1, CSR_SHIFT, 32'(sh), rd);
        wb_check(CSR_CTRL, {31'b0, relu}, "wb_rsp.dat CTRL");
        wb_check(CSR_SHIFT, 32'(sh), "wb_rsp.dat SHIFT");
        user = '0;
        user[USER_IS_1X1]  = one;
        user[USER_IS_RELU] = relu;
        for (int k = 0; k < KW; k++) for (int j = 0; j < NBLK; j++) p[k][j] = 0;
        exp_cnt = NBLK;
        watch   = one ? '1 : (KW)'(1 << (KW - 1));
        for (int j = 0; j < NBLK; j++) begin
            stim_state = lcg_next(stim_state);
            len = extreme ? 6 : 2 + int'(stim_state[18:16]) % 5;  // Longest blocks clip both ways
            for (int b = 0; b < len; b++) begin
                stim_state = lcg_next(stim_state);
                pix = (b == 0) ? 8'sd1 : extreme ? ((j % 2) ? 8'sd127 : -8'sd128)
                                                 : stim_state[23:16];
                for (int k = 0; k < KW; k++) begin
                    stim_state = lcg_next(stim_state);
                    w[k] = extreme ? -8'sd128 : stim_state[23:16];
                    p[k][j] += longint'(pix) * longint'(w[k]);  // Bias beat included
                end
                send_beat(pix, b == len - 1, user, w);
            end
            // Expected values for this block
            if (one) begin
                for (int k = 0; k < KW; k++) exp_mem[k][j] = post(p[k][j], relu, sh);
            end else begin
                acc = 0;
                for (int k = 0; k < KW; k++) begin
                    idx = j - (KW - 1 - k);
                    if (idx >= 0) acc += p[k][idx];
                end
                exp_mem[KW-1][j] = post(acc, relu, sh);
            end
        end
        s_beat <= '0;
        s_weights <= '0;
        do @(negedge aclk); while (rd_ptr[KW-1] < NBLK);
        repeat (20) @(posedge aclk);
        for (int k = 0; k < KW; k++) begin
            assert (!watch[k] || rd_ptr[k] == exp_cnt)
                else fail_plain("an output lane gave fewer results than blocks were sent");
        end
        wb_check(CSR_COUNT, 32'(seen_cnt), "wb_rsp.dat COUNT");
        wb_access(1'b1, CSR_CTRL, {31'b0, relu}, rd);
        wb_check(CSR_COUNT, 32'b0, "wb_rsp.dat COUNT after clear");
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the DUT stopped producing results in time");
        $display("Regression failed");
        $fatal(1);
    end

    initial begin
        aclk       = 1'b0;
        stim_state = 32'd10;
        rdy_state  = lcg_next(32'd10);
        exp_cnt    = 0;
        watch      = '0;
        rst       <= 1'b1;
        s_beat    <= '0;
        s_weights <= '0;
        wb_req    <= '0;
        @(posedge aclk);
        run_phase(1'b1, 1'b0, 0, 1'b0);  // 1x1, plain sums
        run_phase(1'b0, 1'b0, 0, 1'b0);  // Snaked sums with edge blocks
        run_phase(1'b0, 1'b1, 3, 1'b0);  // ReLU and shift
        run_phase(1'b0, 1'b0, 0, 1'b1);  // Both saturation bounds
        $display("Regression passed");
        $finish;
    end

endmodule
